// File: source/drawPkg.sv
package drawPkg;

	////////////////////////////////////////////////
	// Frame store geometry
	////////////////////////////////////////////////
	localparam int frameWidth = 160; // Stored columns.
	localparam int frameHeight = 120; // Stored rows.
	localparam int pixelScale = 4; // Raster pixels per stored pixel.
	localparam int frameSize = frameWidth * frameHeight; // Entries per buffer.

	// 640x480 raster with both syncs active low.
	localparam int hActive = 640;
	localparam int hFront = 16;
	localparam int hSync = 96;
	localparam int hTotal = 800; // Includes the back porch.
	localparam int vActive = 480;
	localparam int vFront = 10;
	localparam int vSync = 2;
	localparam int vTotal = 525;
	localparam int scanCountWidth = 10; // Holds 0 to 799.

	////////////////////////////////////////////////
	// Command queue and word layout
	////////////////////////////////////////////////
	localparam int queueDepth = 16;
	localparam int queuePtrWidth = $clog2(queueDepth);
	localparam int wordWidth = 16;
	localparam int opcodeLsb = 14; // First word bits 15..14.
	localparam int rowLsb = 7; // First word bits 13..7.
	localparam int colorLsb = 4; // First word bits 6..4.
	localparam int leftLsb = 8; // Second word bits 15..8.
	localparam int rightLsb = 0; // Second word bits 7..0.

	typedef logic [2:0] colorT; // {R, G, B}.
	typedef logic [7:0] columnT;
	typedef logic [6:0] rowT;
	typedef logic [14:0] pixelAddrT; // Index inside one buffer.
	typedef logic [wordWidth-1:0] commandWordT;
	typedef enum logic [1:0] {opSpan = 2'd0, opSwap = 2'd1} opcodeT;

endpackage

// File: source/drawIf.sv
`timescale 1ns/100ps

// Decoded command from decoder to painter.
interface spanIf;
	logic start; // One cycle strobe.
	logic isSwap;
	drawPkg::rowT row;
	drawPkg::columnT left;
	drawPkg::columnT right;
	drawPkg::colorT color;
	logic busy; // High from the cycle after start to completion.
	modport decoder (output start, isSwap, row, left, right, color, input busy);
	modport painter (input start, isSwap, row, left, right, color, output busy);
endinterface

// Pixel writes and swap handshake from painter to frame store.
interface pixelIf;
	logic we;
	drawPkg::rowT row;
	drawPkg::columnT column;
	drawPkg::colorT color;
	logic swapRequest; // One cycle pulse.
	logic swapDone; // Pulses once the exchange took effect.
	modport painter (output we, row, column, color, swapRequest, input swapDone);
	modport buffer (input we, row, column, color, swapRequest, output swapDone);
endinterface

// Raster position from video timing.
interface scanIf;
	logic active;
	logic [drawPkg::scanCountWidth-1:0] x;
	logic [drawPkg::scanCountWidth-1:0] y;
	logic frameEnd; // x=0 and y=480.
	modport timing (output active, x, y, frameEnd);
	modport buffer (input active, x, y, frameEnd);
endinterface

// File: source/commandQueue.sv
`timescale 1ns/100ps

module commandQueue (
	input logic clk,
	input logic reset,
	input logic we,
	input drawPkg::commandWordT data,
	input logic pop,
	output drawPkg::commandWordT head,
	output logic notEmpty,
	output logic full
);

	drawPkg::commandWordT store [drawPkg::queueDepth]; // Word storage.
	logic [drawPkg::queuePtrWidth-1:0] wrPtr; // Next free slot.
	logic [drawPkg::queuePtrWidth-1:0] rdPtr; // Oldest word.
	logic [drawPkg::queuePtrWidth:0] count; // Words held, up to queueDepth.
	logic push;
	logic take;

	assign push = we && !full; // Writes while full are dropped.
	assign take = pop && notEmpty;
	assign notEmpty = (count != '0);
	assign full = (count == drawPkg::queueDepth);
	assign head = store[rdPtr]; // Visible the cycle after the write.

	always_ff @(posedge clk)
	begin
		if (push)
			store[wrPtr] <= data;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0; // Empty, so full is low.
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1; // Wraps at queueDepth.
			if (take)
				rdPtr <= rdPtr + 1'b1;
			case ({push, take})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither.
			endcase
		end
	end

endmodule

// File: source/commandDecoder.sv
`timescale 1ns/100ps

module commandDecoder (
	input logic clk,
	input logic reset,
	input drawPkg::commandWordT head,
	input logic notEmpty,
	output logic pop,
	spanIf.decoder span
);

	typedef enum logic [1:0] {sFirst, sSecond, sDecode, sIssue} stateT;

	stateT state;
	drawPkg::commandWordT firstWord; // Opcode, row and colour.
	drawPkg::commandWordT secondWord; // Left and right column.
	logic validOp; // Known opcode.

	// Pop while fetching and a word is waiting.
	assign pop = ((state == sFirst) || (state == sSecond)) && notEmpty;

	////////////////////////////////////////////////
	// Fetch, decode and issue
	////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sFirst;
			span.start <= 1'b0;
		end
		else
		begin
			span.start <= 1'b0; // Strobe lasts one cycle.
			case (state)
				sFirst:
					if (notEmpty)
						state <= sSecond;
				sSecond:
					if (notEmpty)
						state <= sDecode;
				sDecode:
					state <= sIssue;
				sIssue:
					if (!span.busy)
					begin
						span.start <= validOp; // Unknown opcodes vanish here.
						state <= sFirst;
					end
				default:
					state <= sFirst;
			endcase
		end
	end

	// Word capture and field split.
	always_ff @(posedge clk)
	begin
		if (state == sFirst && notEmpty)
			firstWord <= head;
		if (state == sSecond && notEmpty)
			secondWord <= head;
		if (state == sDecode)
		begin
			span.row <= firstWord[drawPkg::rowLsb +: 7];
			span.color <= firstWord[drawPkg::colorLsb +: 3];
			span.left <= secondWord[drawPkg::leftLsb +: 8];
			span.right <= secondWord[drawPkg::rightLsb +: 8]; // Unused by swaps.
			case (drawPkg::opcodeT'(firstWord[drawPkg::opcodeLsb +: 2]))
				drawPkg::opSpan:
				begin
					validOp <= 1'b1;
					span.isSwap <= 1'b0;
				end
				drawPkg::opSwap:
				begin
					validOp <= 1'b1;
					span.isSwap <= 1'b1;
				end
				default:
				begin
					validOp <= 1'b0;
					span.isSwap <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: source/spanPainter.sv
`timescale 1ns/100ps

module spanPainter (
	input logic clk,
	input logic reset,
	spanIf.painter span,
	pixelIf.painter pixel
);

	typedef enum logic [1:0] {sIdle, sDraw, sDone, sSwap} stateT;

	stateT state;
	drawPkg::columnT column; // Pixel being written.
	drawPkg::columnT lastColumn; // Clipped right end.
	drawPkg::columnT clippedRight;
	logic spanValid;

	// Clip right to the store and reject bad spans.
	assign clippedRight = (span.right > drawPkg::columnT'(drawPkg::frameWidth - 1)) ?
		drawPkg::columnT'(drawPkg::frameWidth - 1) : span.right;
	assign spanValid = (span.left <= clippedRight) &&
		(span.row < drawPkg::rowT'(drawPkg::frameHeight));

	assign span.busy = (state != sIdle); // Rises the cycle after start.
	assign pixel.we = (state == sDraw); // One pixel per cycle.
	assign pixel.column = column;

	////////////////////////////////////////////////
	// Span stepping and swap hold
	////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sIdle;
			pixel.swapRequest <= 1'b0;
		end
		else
		begin
			pixel.swapRequest <= 1'b0;
			case (state)
				sIdle:
					if (span.start)
					begin
						if (span.isSwap)
						begin
							state <= sSwap;
							pixel.swapRequest <= 1'b1; // Single pulse.
						end
						else if (spanValid)
							state <= sDraw;
						else
							state <= sDone; // Nothing drawn.
					end
				sDraw:
					if (column == lastColumn)
						state <= sDone;
				sDone:
					state <= sIdle; // Extra busy cycle.
				sSwap:
					if (pixel.swapDone)
						state <= sIdle; // Back buffer is free again.
				default:
					state <= sIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == sIdle && span.start)
		begin
			column <= span.left;
			lastColumn <= clippedRight;
			pixel.row <= span.row;
			pixel.color <= span.color;
		end
		else if (state == sDraw)
			column <= column + 8'd1;
	end

endmodule

// File: source/frameBuffer.sv
`timescale 1ns/100ps

module frameBuffer (
	input logic clk,
	input logic reset,
	output drawPkg::colorT color,
	pixelIf.buffer pixel,
	scanIf.buffer scan
);

	// Two halves, powering up black.
	drawPkg::colorT store [2][drawPkg::frameSize] = '{default: '0};
	logic frontSelect; // Half on display.
	logic pending; // Swap waiting for frameEnd.
	drawPkg::pixelAddrT writeAddr;
	drawPkg::pixelAddrT readAddr;
	drawPkg::colorT readData;
	logic activeDelay; // Active, aligned with readData.

	assign writeAddr = drawPkg::pixelAddrT'(pixel.row * drawPkg::frameWidth + pixel.column);
	// Each stored pixel covers a 4x4 raster block.
	assign readAddr = scan.active ?
		drawPkg::pixelAddrT'((scan.y / drawPkg::pixelScale) * drawPkg::frameWidth +
		scan.x / drawPkg::pixelScale) : '0;

	////////////////////////////////////////////////
	// Store ports
	////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (pixel.we)
			store[~frontSelect][writeAddr] <= pixel.color; // Back half only.
	end

	always_ff @(posedge clk)
	begin
		readData <= store[frontSelect][readAddr]; // Stage one.
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activeDelay <= 1'b0;
			color <= '0;
		end
		else
		begin
			activeDelay <= scan.active;
			color <= activeDelay ? readData : '0; // Stage two, black when blank.
		end
	end

	// Deferred swap at the end of the visible frame.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			frontSelect <= 1'b0; // Buffer 0 shown first.
			pending <= 1'b0;
			pixel.swapDone <= 1'b0;
		end
		else
		begin
			pixel.swapDone <= 1'b0;
			if (pixel.swapRequest)
				pending <= 1'b1;
			if (scan.frameEnd && (pending || pixel.swapRequest))
			begin
				frontSelect <= ~frontSelect;
				pending <= 1'b0;
				pixel.swapDone <= 1'b1;
			end
		end
	end

endmodule

// File: source/videoTiming.sv
`timescale 1ns/100ps

module videoTiming (
	input logic clk,
	input logic reset,
	output logic hsyncRaw,
	output logic vsyncRaw,
	scanIf.timing scan
);

	logic [drawPkg::scanCountWidth-1:0] hCount; // Pixel within line.
	logic [drawPkg::scanCountWidth-1:0] vCount; // Line within frame.
	logic lineEnd;

	assign lineEnd = (hCount == drawPkg::hTotal - 1);

	////////////////////////////////////////////////
	// Raster counters
	////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (lineEnd)
		begin
			hCount <= '0;
			if (vCount == drawPkg::vTotal - 1)
				vCount <= '0; // Next frame.
			else
				vCount <= vCount + 1'b1;
		end
		else
			hCount <= hCount + 1'b1;
	end

	// Sync windows after the front porch, active low.
	assign hsyncRaw = !((hCount >= drawPkg::hActive + drawPkg::hFront) &&
		(hCount < drawPkg::hActive + drawPkg::hFront + drawPkg::hSync));
	assign vsyncRaw = !((vCount >= drawPkg::vActive + drawPkg::vFront) &&
		(vCount < drawPkg::vActive + drawPkg::vFront + drawPkg::vSync));

	assign scan.active = (hCount < drawPkg::hActive) && (vCount < drawPkg::vActive);
	assign scan.x = hCount;
	assign scan.y = vCount;
	assign scan.frameEnd = (hCount == '0) && (vCount == drawPkg::vActive); // First blank line.

endmodule

// File: source/drawUnit.sv
`timescale 1ns/100ps

module drawUnit (
	input logic clk,
	input logic reset,
	input logic we,
	input drawPkg::commandWordT data,
	output logic full,
	output drawPkg::colorT color,
	output logic hsync,
	output logic vsync
);

	drawPkg::commandWordT head; // Oldest queued word.
	logic notEmpty;
	logic pop;
	logic hsyncRaw;
	logic vsyncRaw;
	logic [1:0] hsyncDelay; // Matches the two colour stages.
	logic [1:0] vsyncDelay;

	spanIf spanBus ();
	pixelIf pixelBus ();
	scanIf scanBus ();

	commandQueue queue (
		.clk(clk),
		.reset(reset),
		.we(we),
		.data(data),
		.pop(pop),
		.head(head),
		.notEmpty(notEmpty),
		.full(full)
	);

	commandDecoder decoder (.clk(clk), .reset(reset), .head(head), .notEmpty(notEmpty),
		.pop(pop), .span(spanBus.decoder));

	spanPainter painter (.clk(clk), .reset(reset), .span(spanBus.painter),
		.pixel(pixelBus.painter));

	frameBuffer buffer (.clk(clk), .reset(reset), .color(color), .pixel(pixelBus.buffer),
		.scan(scanBus.buffer));

	videoTiming timing (.clk(clk), .reset(reset), .hsyncRaw(hsyncRaw), .vsyncRaw(vsyncRaw),
		.scan(scanBus.timing));

	////////////////////////////////////////////////
	// Sync alignment
	////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hsyncDelay <= 2'b11; // Idle high.
			vsyncDelay <= 2'b11;
		end
		else
		begin
			hsyncDelay <= {hsyncDelay[0], hsyncRaw};
			vsyncDelay <= {vsyncDelay[0], vsyncRaw};
		end
	end

	assign hsync = hsyncDelay[1];
	assign vsync = vsyncDelay[1];

endmodule

// File: testbench/drawUnitTb.sv
`timescale 1ns/100ps

module drawUnitTb;

	localparam int vsyncLimit = 450000; // A little over one frame of cycles.
	localparam int fullLimit = 5000;

	typedef struct {
		string name; // Test group the row belongs to.
		drawPkg::opcodeT op;
		int row;
		int shade;
		int left;
		int right;
	} stepT;

	logic clk = 1'b0;
	logic reset;
	logic we;
	drawPkg::commandWordT data;
	logic full;
	drawPkg::colorT color;
	logic hsync;
	logic vsync;

	drawPkg::colorT model [2][drawPkg::frameHeight][drawPkg::frameWidth] = '{default: '0};
	bit modelFront = 1'b0; // Buffer 0 on display after reset.
	int unsigned lcgState = 68160;
	int testErrors;
	int passCount = 0;
	int failCount = 0;
	bit colorReported; // Only the first colour mismatch of a scan is shown.
	bit sawFull;

	stepT steps [14] = '{
		'{"three spans", drawPkg::opSpan, 10, 5, 20, 40},
		'{"three spans", drawPkg::opSpan, 60, 2, 0, 0}, // Single pixel.
		'{"three spans", drawPkg::opSpan, 119, 7, 150, 159}, // Bottom right corner.
		'{"three spans", drawPkg::opSwap, 0, 0, 0, 0},
		'{"clipping", drawPkg::opSpan, 30, 4, 50, 40}, // Left past right.
		'{"clipping", drawPkg::opSpan, 120, 6, 0, 100}, // First row outside.
		'{"clipping", drawPkg::opSpan, 127, 3, 10, 20},
		'{"clipping", drawPkg::opSpan, 80, 5, 140, 200}, // Stops at column 159.
		'{"clipping", drawPkg::opcodeT'(2'd3), 5, 7, 0, 159}, // Unknown opcode.
		'{"clipping", drawPkg::opSwap, 0, 0, 0, 0},
		'{"after swap", drawPkg::opSpan, 40, 1, 10, 100},
		'{"after swap", drawPkg::opSpan, 41, 2, 0, 159},
		'{"second swap", drawPkg::opSwap, 0, 0, 0, 0},
		'{"second swap", drawPkg::opSpan, 42, 6, 0, 50} // Lands behind the new front.
	};

	drawUnit u_dut (.clk(clk), .reset(reset), .we(we), .data(data), .full(full),
		.color(color), .hsync(hsync), .vsync(vsync));

	always #50 clk = ~clk; // 100 ns pixel clock.

	////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////
	function automatic int nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return int'((lcgState >> 16) & 32'h7fff); // Upper bits vary most.
	endfunction

	task automatic reportTimeout(input string waitName);
		$display("Timeout while waiting for %s", waitName);
		testErrors++;
	endtask

	// Previous word is taken at the edge, then wait out full.
	task automatic pushWord(input drawPkg::commandWordT word);
		int waitCount;
		waitCount = 0;
		@(posedge clk);
		#1;
		we = 1'b0;
		while (full === 1'b1 && waitCount < fullLimit)
		begin
			sawFull = 1'b1;
			@(posedge clk);
			#1;
			waitCount++;
		end
		if (full === 1'b1)
			reportTimeout("full to clear");
		else
		begin
			we = 1'b1;
			data = word;
		end
	endtask

	task automatic finishWrites();
		@(posedge clk);
		#1;
		we = 1'b0; // Last word went in at this edge.
	endtask

	// Span rules: row below 120, left not past right, right clipped to 159.
	task automatic paintModel(input int row, input int left, input int right,
		input drawPkg::colorT shade);
		int lastColumn;
		int column;
		lastColumn = (right > drawPkg::frameWidth - 1) ? drawPkg::frameWidth - 1 : right;
		if (row < drawPkg::frameHeight && left <= lastColumn)
			for (column = left; column <= lastColumn; column++)
				model[!modelFront][row][column] = shade; // Back buffer.
	endtask

	task automatic applyCommand(input drawPkg::opcodeT op, input int row, input int shade,
		input int left, input int right);
		drawPkg::commandWordT first;
		drawPkg::commandWordT second;
		first = {op, drawPkg::rowT'(row), drawPkg::colorT'(shade), 4'b0000};
		second = {drawPkg::columnT'(left), drawPkg::columnT'(right)};
		pushWord(first);
		pushWord(second);
		if (op == drawPkg::opSpan)
			paintModel(row, left, right, drawPkg::colorT'(shade));
		else if (op == drawPkg::opSwap)
			modelFront = !modelFront;
	endtask

	task automatic applyTable(input string name);
		foreach (steps[i])
			if (steps[i].name == name)
				applyCommand(steps[i].op, steps[i].row, steps[i].shade, steps[i].left,
					steps[i].right);
		finishWrites();
	endtask

	////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////
	task automatic checkColor(input string name, input int x, input int y,
		input drawPkg::colorT expected, input drawPkg::colorT actual);
		if (actual !== expected)
		begin
			testErrors++;
			if (!colorReported)
				$display("[ERROR] %s at x=%0d y=%0d: expected %0d, actual %0d", name, x, y,
					expected, actual);
			colorReported = 1'b1;
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			testErrors++;
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	// Sampled at the falling edge, so vsync and colour are settled.
	task automatic waitVsyncRise(output bit found);
		int waitCount;
		found = 1'b0;
		waitCount = 0;
		@(negedge clk);
		while (vsync !== 1'b0 && waitCount < vsyncLimit)
		begin
			@(negedge clk);
			waitCount++;
		end
		if (vsync !== 1'b0)
			reportTimeout("vsync low");
		else
		begin
			waitCount = 0;
			while (vsync !== 1'b1 && waitCount < vsyncLimit)
			begin
				@(negedge clk);
				waitCount++;
			end
			if (vsync !== 1'b1)
				reportTimeout("vsync rising edge");
			else
				found = 1'b1;
		end
	endtask

	// Vsync rises at line 492, hsync falls at pixel 656 of each line.
	task automatic scanFrame(input string name);
		bit found;
		bit syncReported;
		int x;
		int y;
		int cycles;
		logic lastHsync;
		drawPkg::colorT expected;
		waitVsyncRise(found);
		if (found)
		begin
			x = 0;
			y = drawPkg::vActive + drawPkg::vFront + drawPkg::vSync;
			cycles = (drawPkg::vTotal - y + drawPkg::vActive) * drawPkg::hTotal; // To line 480.
			colorReported = 1'b0;
			syncReported = 1'b0;
			lastHsync = hsync;
			repeat (cycles)
			begin
				if (x < drawPkg::hActive && y < drawPkg::vActive)
					expected = model[modelFront][y / drawPkg::pixelScale][x / drawPkg::pixelScale];
				else
					expected = '0; // Blanking is black.
				checkColor(name, x, y, expected, color);
				@(negedge clk);
				x++;
				if (x == drawPkg::hTotal)
				begin
					x = 0;
					y = (y + 1) % drawPkg::vTotal;
				end
				if (lastHsync === 1'b1 && hsync === 1'b0)
				begin
					if (x != drawPkg::hActive + drawPkg::hFront && !syncReported)
					begin
						$display("%s: hsync fell at x=%0d on line %0d, out of place", name, x, y);
						testErrors++;
						syncReported = 1'b1;
					end
					x = drawPkg::hActive + drawPkg::hFront; // Resync on the edge.
				end
				lastHsync = hsync;
			end
		end
	endtask

	task automatic finishTest(input string name);
		if (testErrors == 0)
		begin
			passCount++;
			$display("PASS: %s", name);
		end
		else
		begin
			failCount++;
			$display("FAIL: %s (%0d errors)", name, testErrors);
		end
	endtask

	////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////
	initial
	begin
		bit found;
		int row;
		int shade;
		int left;
		int right;
		we = 1'b0;
		data = '0;
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		testErrors = 0; // Empty queue and a black frame.
		checkFlag("reset full", 1'b0, full);
		scanFrame("reset black");
		finishTest("reset black");

		testErrors = 0;
		waitVsyncRise(found); // Commands go in early in a frame.
		applyTable("three spans");
		scanFrame("three spans");
		finishTest("three spans");

		testErrors = 0;
		waitVsyncRise(found);
		applyTable("clipping");
		scanFrame("clipping");
		finishTest("clipping");

		testErrors = 0;
		waitVsyncRise(found);
		applyTable("after swap");
		scanFrame("deferred swap before");
		waitVsyncRise(found);
		applyTable("second swap");
		scanFrame("deferred swap after");
		finishTest("deferred swap");

		testErrors = 0;
		sawFull = 1'b0;
		waitVsyncRise(found);
		for (int i = 0; i < 20; i++)
			applyCommand(drawPkg::opSpan, 20 + i * 4, i % 7 + 1, i, 159 - i); // Wide spans.
		applyCommand(drawPkg::opSwap, 0, 0, 0, 0);
		finishWrites();
		checkFlag("burst full", 1'b1, sawFull);
		scanFrame("back-pressure");
		checkFlag("drained full", 1'b0, full);
		finishTest("back-pressure");

		testErrors = 0;
		waitVsyncRise(found);
		for (int i = 0; i < 20; i++)
		begin
			row = nextRandom() % 128; // Some rows fall outside.
			shade = nextRandom() % 8;
			left = nextRandom() % 170;
			right = left + nextRandom() % 48 - 4;
			if (right < 0)
				right = 0;
			applyCommand(drawPkg::opSpan, row, shade, left, right);
		end
		applyCommand(drawPkg::opSwap, 0, 0, 0, 0);
		finishWrites();
		scanFrame("random spans");
		finishTest("random spans");

		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: build.f
source/drawPkg.sv
source/drawIf.sv
source/commandQueue.sv
source/commandDecoder.sv
source/spanPainter.sv
source/frameBuffer.sv
source/videoTiming.sv
source/drawUnit.sv
testbench/drawUnitTb.sv

// File: Bender.yml
package:
  name: draw_unit

sources:
  - source/drawPkg.sv
  - source/drawIf.sv
  - source/commandQueue.sv
  - source/commandDecoder.sv
  - source/spanPainter.sv
  - source/frameBuffer.sv
  - source/videoTiming.sv
  - source/drawUnit.sv
  - target: test
    files:
      - testbench/drawUnitTb.sv
